// File: common/pwm_pkg.sv
// ========================================
// pwm array shared definitions
// widths, channel count, adder latency
// and the enums used across the design.
// ========================================

package pwm_pkg;

  // ========================================
  // sizes
  // ========================================

  localparam int WIDTH = 13;           // cycle, duty, phase, counter.
  localparam int CHANNELS = 8;
  localparam int CH_BITS = 3;          // channel index.

  // register stages from operands to sum in addsub.
  localparam int ADDSUB_LATENCY = 2;

  // ========================================
  // enums
  // ========================================

  // field selected by a host write.
  typedef enum logic [1:0] {
    FIELD_CYCLE,
    FIELD_DUTY,
    FIELD_PHASE
  } field_t;

  // preconditioner sequencing.
  typedef enum logic [1:0] {
    ST_WAIT,
    ST_RUN,
    ST_DONE
  } prec_state_t;

endpackage

// File: src/addsub.sv
// ========================================
// registered signed adder/subtractor
// operands and select are registered, then
// the result, for two cycles of latency.
// ========================================

`timescale 1ns/1ps

module addsub #(
  parameter int WIDTH = 15
) (
  input  logic                    CLK,
  input  logic signed [WIDTH-1:0] a,
  input  logic signed [WIDTH-1:0] b,
  input  bit                      add,
  output logic signed [WIDTH-1:0] s
);

  logic signed [WIDTH-1:0] a_q;
  logic signed [WIDTH-1:0] b_q;
  logic                    add_q;

  always_ff @(posedge CLK) begin
    a_q   <= a;                            // stage 1.
    b_q   <= b;
    add_q <= add;
    s     <= add_q ? a_q + b_q : a_q - b_q; // stage 2.
  end

endmodule

// File: src/pwm_config_regs.sv
// ========================================
// pwm configuration banks
// host writes land in staging; a commit
// copies staging to active and starts the
// preconditioner.
// ========================================

`timescale 1ns/1ps

module pwm_config_regs (
  input  logic                       CLK,
  input  logic                       rst,
  input  logic                       wr,
  input  logic [pwm_pkg::CH_BITS-1:0] wr_ch,
  input  pwm_pkg::field_t            wr_field,
  input  logic [pwm_pkg::WIDTH-1:0]  wr_data,
  input  logic                       commit,
  input  logic                       update,
  output logic [pwm_pkg::WIDTH-1:0]  act_cycle [pwm_pkg::CHANNELS],
  output logic [pwm_pkg::WIDTH-1:0]  act_duty  [pwm_pkg::CHANNELS],
  output logic [pwm_pkg::WIDTH-1:0]  act_phase [pwm_pkg::CHANNELS],
  output logic                       start,
  output logic                       busy
);

  logic [pwm_pkg::WIDTH-1:0] stg_cycle [pwm_pkg::CHANNELS];
  logic [pwm_pkg::WIDTH-1:0] stg_duty  [pwm_pkg::CHANNELS];
  logic [pwm_pkg::WIDTH-1:0] stg_phase [pwm_pkg::CHANNELS];
  logic                      commit_ok;

  assign commit_ok = commit & ~busy;   // ignored while pipeline runs.

  // ========================================
  // staging bank
  // ========================================

  always_ff @(posedge CLK) begin
    if (rst) begin
      for (int i = 0; i < pwm_pkg::CHANNELS; i++) begin
        stg_cycle[i] <= '0;
        stg_duty[i]  <= '0;
        stg_phase[i] <= '0;
      end
    end else if (wr) begin
      case (wr_field)
        pwm_pkg::FIELD_CYCLE: stg_cycle[wr_ch] <= wr_data;
        pwm_pkg::FIELD_DUTY:  stg_duty[wr_ch]  <= wr_data;
        pwm_pkg::FIELD_PHASE: stg_phase[wr_ch] <= wr_data;
        default: ;                     // unused code, dropped.
      endcase
    end
  end

  // ========================================
  // active bank and handshake flags
  // ========================================

  always_ff @(posedge CLK) begin
    if (rst) begin
      for (int i = 0; i < pwm_pkg::CHANNELS; i++) begin
        act_cycle[i] <= '0;
        act_duty[i]  <= '0;
        act_phase[i] <= '0;
      end
      start <= 1'b0;
      busy  <= 1'b0;
    end else begin
      start <= commit_ok;
      if (commit_ok) begin
        act_cycle <= stg_cycle;        // frozen until next commit.
        act_duty  <= stg_duty;
        act_phase <= stg_phase;
        busy      <= 1'b1;
      end else if (update) begin
        busy <= 1'b0;
      end
    end
  end

  a_wr_ch_range: assert property (@(posedge CLK) disable iff (rst)
    wr |-> wr_ch < pwm_pkg::CHANNELS);

  // a new start only follows an idle cycle.
  a_start_idle: assert property (@(posedge CLK) disable iff (rst)
    start |-> !$past(busy));

endmodule

// File: pwm/pwm_preconditioner.sv
// ========================================
// pwm rise/fall preconditioner
// per channel: centre = cycle - phase,
// rise/fall around it, folded into cycle.
// ========================================

`timescale 1ns/1ps

module pwm_preconditioner (
  input  logic                      CLK,
  input  logic                      rst,
  input  logic                      start,
  input  logic [pwm_pkg::WIDTH-1:0] cycle [pwm_pkg::CHANNELS],
  input  logic [pwm_pkg::WIDTH-1:0] duty  [pwm_pkg::CHANNELS],
  input  logic [pwm_pkg::WIDTH-1:0] phase [pwm_pkg::CHANNELS],
  output logic [pwm_pkg::WIDTH-1:0] rise  [pwm_pkg::CHANNELS],
  output logic [pwm_pkg::WIDTH-1:0] fall  [pwm_pkg::CHANNELS],
  output logic                      update
);

  // two guard bits keep negative and doubled values.
  typedef logic signed [pwm_pkg::WIDTH+1:0] ext_t;

  pwm_pkg::prec_state_t state;

  logic [pwm_pkg::CH_BITS:0]   issue_cnt;
  logic [pwm_pkg::CH_BITS-1:0] issue_idx;
  logic                        issue;

  // valid/index travel with the data through all three stages.
  logic                        vld_d [3*pwm_pkg::ADDSUB_LATENCY+3];
  logic [pwm_pkg::CH_BITS-1:0] idx_d [3*pwm_pkg::ADDSUB_LATENCY+3];
  logic [pwm_pkg::WIDTH-1:0]   duty_d [pwm_pkg::ADDSUB_LATENCY+1];
  ext_t                        cyc_d [2*pwm_pkg::ADDSUB_LATENCY+2];

  ext_t a_phase, b_phase, s_centre;
  ext_t a_half, b_half, s_half;
  ext_t a_rise, b_rise, s_rise;
  ext_t a_fall, b_fall, s_fall;
  ext_t a_frise, b_frise, s_frise;
  ext_t a_ffall, b_ffall, s_ffall;
  logic frise_add;

  logic [pwm_pkg::WIDTH-1:0] rise_buf [pwm_pkg::CHANNELS];
  logic [pwm_pkg::WIDTH-1:0] fall_buf [pwm_pkg::CHANNELS];

  assign issue_idx = issue_cnt[pwm_pkg::CH_BITS-1:0];
  assign issue     = (state == pwm_pkg::ST_RUN) && (issue_cnt < pwm_pkg::CHANNELS);

  addsub #(.WIDTH(pwm_pkg::WIDTH + 2)) sub_phase (
    .CLK(CLK), .a(a_phase), .b(b_phase), .add(1'b0), .s(s_centre)
  );
  addsub #(.WIDTH(pwm_pkg::WIDTH + 2)) add_half (
    .CLK(CLK), .a(a_half), .b(b_half), .add(1'b1), .s(s_half)
  );
  addsub #(.WIDTH(pwm_pkg::WIDTH + 2)) sub_rise (
    .CLK(CLK), .a(a_rise), .b(b_rise), .add(1'b0), .s(s_rise)
  );
  addsub #(.WIDTH(pwm_pkg::WIDTH + 2)) add_fall (
    .CLK(CLK), .a(a_fall), .b(b_fall), .add(1'b1), .s(s_fall)
  );
  addsub #(.WIDTH(pwm_pkg::WIDTH + 2)) fold_rise (
    .CLK(CLK), .a(a_frise), .b(b_frise), .add(frise_add), .s(s_frise)
  );
  addsub #(.WIDTH(pwm_pkg::WIDTH + 2)) fold_fall (
    .CLK(CLK), .a(a_ffall), .b(b_ffall), .add(1'b0), .s(s_ffall)
  );

  // ========================================
  // datapath stages
  // ========================================

  always_ff @(posedge CLK) begin
    // stage 1: centre and ceil(duty/2).
    a_phase <= ext_t'(cycle[issue_idx]);
    b_phase <= ext_t'(phase[issue_idx]);
    a_half  <= ext_t'(duty[issue_idx][pwm_pkg::WIDTH-1:1]);
    b_half  <= ext_t'(duty[issue_idx][0]);
    duty_d[0] <= duty[issue_idx];
    cyc_d[0]  <= ext_t'(cycle[issue_idx]);
    for (int i = 1; i <= pwm_pkg::ADDSUB_LATENCY; i++) begin
      duty_d[i] <= duty_d[i-1];
    end
    for (int i = 1; i < 2*pwm_pkg::ADDSUB_LATENCY+2; i++) begin
      cyc_d[i] <= cyc_d[i-1];
    end
    for (int i = 1; i < 3*pwm_pkg::ADDSUB_LATENCY+3; i++) begin
      idx_d[i] <= idx_d[i-1];
    end
    idx_d[0] <= issue_idx;

    // stage 2: raw rise and fall.
    a_rise <= s_centre;
    b_rise <= ext_t'(duty_d[pwm_pkg::ADDSUB_LATENCY][pwm_pkg::WIDTH-1:1]);
    a_fall <= s_centre;
    b_fall <= s_half;

    // stage 3: fold into 0 .. cycle-1.
    a_frise <= s_rise;
    a_ffall <= s_fall;
    if (s_rise[pwm_pkg::WIDTH+1]) begin
      b_frise   <= cyc_d[2*pwm_pkg::ADDSUB_LATENCY+1];
      frise_add <= 1'b1;                // negative, add a cycle.
    end else if (s_rise >= cyc_d[2*pwm_pkg::ADDSUB_LATENCY+1]) begin
      b_frise   <= cyc_d[2*pwm_pkg::ADDSUB_LATENCY+1];
      frise_add <= 1'b0;
    end else begin
      b_frise   <= '0;
      frise_add <= 1'b1;
    end
    if (s_fall >= cyc_d[2*pwm_pkg::ADDSUB_LATENCY+1]) begin
      b_ffall <= cyc_d[2*pwm_pkg::ADDSUB_LATENCY+1];
    end else begin
      b_ffall <= '0;
    end

    if (vld_d[3*pwm_pkg::ADDSUB_LATENCY+2]) begin
      rise_buf[idx_d[3*pwm_pkg::ADDSUB_LATENCY+2]] <= s_frise[pwm_pkg::WIDTH-1:0];
      fall_buf[idx_d[3*pwm_pkg::ADDSUB_LATENCY+2]] <= s_ffall[pwm_pkg::WIDTH-1:0];
    end
    if (state == pwm_pkg::ST_DONE) begin
      rise <= rise_buf;                 // all channels swap together.
      fall <= fall_buf;
    end
  end

  // ========================================
  // sequencing FSM
  // ========================================

  always_ff @(posedge CLK) begin
    if (rst) begin
      state     <= pwm_pkg::ST_WAIT;
      issue_cnt <= '0;
      update    <= 1'b0;
      for (int i = 0; i < 3*pwm_pkg::ADDSUB_LATENCY+3; i++) begin
        vld_d[i] <= 1'b0;
      end
    end else begin
      update   <= 1'b0;
      vld_d[0] <= issue;
      for (int i = 1; i < 3*pwm_pkg::ADDSUB_LATENCY+3; i++) begin
        vld_d[i] <= vld_d[i-1];
      end
      case (state)
        pwm_pkg::ST_WAIT: begin
          issue_cnt <= '0;
          if (start) state <= pwm_pkg::ST_RUN;
        end
        pwm_pkg::ST_RUN: begin
          if (issue) issue_cnt <= issue_cnt + 1'b1;
          if (vld_d[3*pwm_pkg::ADDSUB_LATENCY+2] &&
              idx_d[3*pwm_pkg::ADDSUB_LATENCY+2] == pwm_pkg::CH_BITS'(pwm_pkg::CHANNELS-1)) begin
            state <= pwm_pkg::ST_DONE;  // last channel stored.
          end
        end
        pwm_pkg::ST_DONE: begin
          update <= 1'b1;
          state  <= pwm_pkg::ST_WAIT;
        end
        default: state <= pwm_pkg::ST_WAIT;
      endcase
    end
  end

  // busy in the config bank must hold off restarts.
  a_start_in_wait: assert property (@(posedge CLK) disable iff (rst)
    start |-> state == pwm_pkg::ST_WAIT);

endmodule

// File: pwm/pwm_generator.sv
// ========================================
// single pwm channel
// cycle counter plus rise/fall window,
// reloaded and restarted on update.
// ========================================

`timescale 1ns/1ps

module pwm_generator (
  input  logic                      CLK,
  input  logic                      rst,
  input  logic                      update,
  input  logic [pwm_pkg::WIDTH-1:0] cycle_in,
  input  logic [pwm_pkg::WIDTH-1:0] rise_in,
  input  logic [pwm_pkg::WIDTH-1:0] fall_in,
  output logic                      pwm
);

  logic [pwm_pkg::WIDTH-1:0] cycle_q;
  logic [pwm_pkg::WIDTH-1:0] rise_q;
  logic [pwm_pkg::WIDTH-1:0] fall_q;
  logic [pwm_pkg::WIDTH-1:0] t;

  always_ff @(posedge CLK) begin
    if (rst) begin
      cycle_q <= '0;                    // zero cycle holds t at 0.
      rise_q  <= '0;
      fall_q  <= '0;
      t       <= '0;
      pwm     <= 1'b0;
    end else begin
      if (update) begin
        cycle_q <= cycle_in;
        rise_q  <= rise_in;
        fall_q  <= fall_in;
        t       <= '0;
      end else if (t + 1'b1 >= cycle_q) begin
        t <= '0;                        // wrap at cycle-1.
      end else begin
        t <= t + 1'b1;
      end
      if (rise_q <= fall_q) begin
        pwm <= (t >= rise_q) && (t < fall_q);
      end else begin
        pwm <= (t >= rise_q) || (t < fall_q); // wrapped window.
      end
    end
  end

  // folding upstream keeps edges inside the cycle.
  a_edges_in_cycle: assert property (@(posedge CLK) disable iff (rst)
    update |=> (cycle_q == '0) || (rise_q < cycle_q && fall_q < cycle_q));

endmodule

// File: src/pwm_array.sv
// ========================================
// eight channel pwm array top level
// config banks, preconditioner, generators.
// ========================================

`timescale 1ns/1ps

module pwm_array (
  input  logic                        CLK,
  input  logic                        rst,
  input  logic                        wr,
  input  logic [pwm_pkg::CH_BITS-1:0] wr_ch,
  input  pwm_pkg::field_t             wr_field,
  input  logic [pwm_pkg::WIDTH-1:0]   wr_data,
  input  logic                        commit,
  output logic                        busy,
  output logic                        update,
  output logic [pwm_pkg::CHANNELS-1:0] pwm_out
);

  logic [pwm_pkg::WIDTH-1:0] act_cycle [pwm_pkg::CHANNELS];
  logic [pwm_pkg::WIDTH-1:0] act_duty  [pwm_pkg::CHANNELS];
  logic [pwm_pkg::WIDTH-1:0] act_phase [pwm_pkg::CHANNELS];
  logic [pwm_pkg::WIDTH-1:0] rise      [pwm_pkg::CHANNELS];
  logic [pwm_pkg::WIDTH-1:0] fall      [pwm_pkg::CHANNELS];
  logic                      start;

  pwm_config_regs config_regs_i (
    .CLK(CLK), .rst(rst), .wr(wr), .wr_ch(wr_ch), .wr_field(wr_field),
    .wr_data(wr_data), .commit(commit), .update(update),
    .act_cycle(act_cycle), .act_duty(act_duty), .act_phase(act_phase),
    .start(start), .busy(busy)
  );

  pwm_preconditioner preconditioner_i (
    .CLK(CLK), .rst(rst), .start(start),
    .cycle(act_cycle), .duty(act_duty), .phase(act_phase),
    .rise(rise), .fall(fall), .update(update)
  );

  for (genvar i = 0; i < pwm_pkg::CHANNELS; i++) begin : gen_ch
    pwm_generator generator_i (
      .CLK(CLK), .rst(rst), .update(update), .cycle_in(act_cycle[i]),
      .rise_in(rise[i]), .fall_in(fall[i]), .pwm(pwm_out[i])
    );
  end

endmodule

// File: testbench/tb_pwm_array.sv
// ========================================
// pwm array testbench
// table rows of cycle/duty/phase, checked
// against a rise/fall window model.
// ========================================

`timescale 1ns/1ps

module tb_pwm_array;

  localparam int NROWS      = 15;
  localparam int MAX_CYCLE  = 48;
  localparam int PIPE_BOUND = pwm_pkg::CHANNELS + 3 * (pwm_pkg::ADDSUB_LATENCY + 1) + 3 + 8;
  localparam int WR_CYCLES  = 4 * pwm_pkg::CHANNELS + 4;
  localparam longint WATCHDOG_NS =
    longint'(NROWS + 2) * (PIPE_BOUND + 2 * MAX_CYCLE + WR_CYCLES) * 20;

  logic                          CLK;
  logic                          rst;
  logic                          wr;
  logic [pwm_pkg::CH_BITS-1:0]   wr_ch;
  pwm_pkg::field_t               wr_field;
  logic [pwm_pkg::WIDTH-1:0]     wr_data;
  logic                          commit;
  logic                          busy;
  logic                          update;
  logic [pwm_pkg::CHANNELS-1:0]  pwm_out;

  int tab_cycle [NROWS][pwm_pkg::CHANNELS];
  int tab_duty  [NROWS][pwm_pkg::CHANNELS];
  int tab_phase [NROWS][pwm_pkg::CHANNELS];
  int tab_mode  [NROWS];              // 0 plain, 1 next row staged while busy, 2 no writes.
  int seed = 92009;

  pwm_array pwm_array_i (
    .CLK(CLK), .rst(rst), .wr(wr), .wr_ch(wr_ch), .wr_field(wr_field),
    .wr_data(wr_data), .commit(commit), .busy(busy), .update(update),
    .pwm_out(pwm_out)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  initial begin
    #(WATCHDOG_NS);
    stop_with_failure("timeout: the run did not finish in the expected time");
  end

  // ========================================
  // reference model and checks
  // ========================================

  function automatic logic window_bit(input int cyc, input int dty, input int phs, input int t);
    int centre;
    int rise;
    int fall;
    centre = cyc - phs;
    rise   = centre - dty / 2;
    fall   = centre + (dty + 1) / 2;
    if (rise < 0) rise = rise + cyc;
    else if (rise >= cyc) rise = rise - cyc;
    if (fall >= cyc) fall = fall - cyc;
    if (rise <= fall) return (t >= rise) && (t < fall);
    return (t >= rise) || (t < fall);   // wrapped window.
  endfunction

  function automatic logic [pwm_pkg::CHANNELS-1:0] expected_vec(input int r, input int k);
    logic [pwm_pkg::CHANNELS-1:0] v;
    for (int ch = 0; ch < pwm_pkg::CHANNELS; ch++) begin
      v[ch] = window_bit(tab_cycle[r][ch], tab_duty[r][ch], tab_phase[r][ch],
                         k % tab_cycle[r][ch]);
    end
    return v;
  endfunction

  task automatic check_pwm(input logic [pwm_pkg::CHANNELS-1:0] got,
                           input logic [pwm_pkg::CHANNELS-1:0] exp,
                           input int r, input int k);
    if (got !== exp) begin
      stop_with_failure($sformatf("error pwm_out row %0d sample %0d got %h expected %h",
                                  r, k, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error %s got %h expected %h", name, got, exp));
    end
  endtask

  // ========================================
  // host bus
  // ========================================

  task automatic write_field(input int ch, input pwm_pkg::field_t f, input int value);
    @(posedge CLK);
    wr       <= 1'b1;
    wr_ch    <= pwm_pkg::CH_BITS'(ch);
    wr_field <= f;
    wr_data  <= pwm_pkg::WIDTH'(value);
  endtask

  task automatic write_row(input int r);
    for (int ch = 0; ch < pwm_pkg::CHANNELS; ch++) begin
      write_field(ch, pwm_pkg::FIELD_CYCLE, tab_cycle[r][ch]);
      write_field(ch, pwm_pkg::FIELD_DUTY, tab_duty[r][ch]);
      write_field(ch, pwm_pkg::FIELD_PHASE, tab_phase[r][ch]);
    end
  endtask

  // only the fields where row r+1 differs from row r.
  task automatic write_changes(input int r);
    for (int ch = 0; ch < pwm_pkg::CHANNELS; ch++) begin
      if (tab_cycle[r+1][ch] != tab_cycle[r][ch])
        write_field(ch, pwm_pkg::FIELD_CYCLE, tab_cycle[r+1][ch]);
      if (tab_duty[r+1][ch] != tab_duty[r][ch])
        write_field(ch, pwm_pkg::FIELD_DUTY, tab_duty[r+1][ch]);
      if (tab_phase[r+1][ch] != tab_phase[r][ch])
        write_field(ch, pwm_pkg::FIELD_PHASE, tab_phase[r+1][ch]);
    end
    @(posedge CLK);
    wr <= 1'b0;
  endtask

  task automatic pulse_commit;
    @(posedge CLK);
    wr     <= 1'b0;
    commit <= 1'b1;
    @(posedge CLK);
    commit <= 1'b0;
    @(negedge CLK);
    check_flag("busy", busy, 1'b1);
  endtask

  task automatic wait_update;
    int n;
    n = 0;
    do begin
      @(negedge CLK);
      n++;
      if (n > PIPE_BOUND) stop_with_failure("no update pulse arrived after the commit");
    end while (!update);
  endtask

  task automatic load_table;
    tab_cycle[0] = '{20, 20, 24, 30, 16, 40, 33, 48};
    tab_duty[0]  = '{10, 5, 7, 1, 15, 20, 17, 31};
    tab_phase[0] = '{0, 0, 0, 0, 0, 0, 0, 0};
    tab_cycle[1] = '{20, 20, 24, 30, 16, 40, 33, 48};
    tab_duty[1]  = '{10, 12, 9, 20, 6, 30, 11, 40};
    tab_phase[1] = '{18, 2, 1, 25, 10, 35, 30, 3};
    tab_cycle[2] = '{5, 7, 11, 13, 17, 19, 23, 29};
    tab_duty[2]  = '{0, 3, 0, 6, 8, 0, 22, 1};
    tab_phase[2] = '{0, 2, 4, 0, 9, 18, 0, 28};
    tab_cycle[3] = '{12, 12, 12, 12, 36, 36, 36, 36};
    tab_duty[3]  = '{6, 3, 0, 11, 18, 9, 1, 35};
    tab_phase[3] = '{0, 6, 0, 11, 5, 30, 0, 35};
    tab_cycle[4] = '{12, 12, 12, 12, 36, 36, 40, 36};
    tab_duty[4]  = '{2, 3, 0, 11, 18, 20, 1, 35};
    tab_phase[4] = '{0, 0, 0, 11, 5, 30, 0, 35};
    for (int r = 0; r < NROWS; r++) tab_mode[r] = 0;
    tab_mode[3] = 1;
    tab_mode[4] = 2;
    for (int r = 5; r < NROWS; r++) begin
      for (int ch = 0; ch < pwm_pkg::CHANNELS; ch++) begin
        tab_cycle[r][ch] = 2 + ($unsigned($random(seed)) % (MAX_CYCLE - 1));
        tab_duty[r][ch]  = $unsigned($random(seed)) % tab_cycle[r][ch];
        tab_phase[r][ch] = $unsigned($random(seed)) % tab_cycle[r][ch];
      end
    end
  endtask

  // ========================================
  // main sequence
  // ========================================

  initial begin
    int row_max;
    rst      <= 1'b1;
    wr       <= 1'b0;
    wr_ch    <= '0;
    wr_field <= pwm_pkg::FIELD_CYCLE;
    wr_data  <= '0;
    commit   <= 1'b0;
    load_table();
    repeat (16) @(posedge CLK);
    rst <= 1'b0;

    repeat (10) begin                  // idle outputs before any commit.
      @(negedge CLK);
      check_pwm(pwm_out, '0, -1, 0);
      check_flag("busy", busy, 1'b0);
      check_flag("update", update, 1'b0);
    end

    for (int r = 0; r < NROWS; r++) begin
      if (tab_mode[r] != 2) write_row(r);
      pulse_commit();
      if (tab_mode[r] == 1) begin
        write_changes(r);
        pulse_commit();                // ignored, pipeline still running.
        @(negedge CLK);
        check_flag("busy", busy, 1'b1);
      end
      wait_update();
      @(negedge CLK);
      check_flag("update", update, 1'b0);
      check_flag("busy", busy, 1'b0);
      row_max = 0;
      for (int ch = 0; ch < pwm_pkg::CHANNELS; ch++) begin
        if (tab_cycle[r][ch] > row_max) row_max = tab_cycle[r][ch];
      end
      for (int k = 0; k < 2 * row_max; k++) begin
        @(negedge CLK);
        check_pwm(pwm_out, expected_vec(r, k), r, k);
        check_flag("update", update, 1'b0);
      end
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: pwm_array.f
common/pwm_pkg.sv
src/addsub.sv
src/pwm_config_regs.sv
pwm/pwm_preconditioner.sv
pwm/pwm_generator.sv
src/pwm_array.sv
testbench/tb_pwm_array.sv
